//--- verilog.f
ram_writer_pkg.sv
stream_fifo.sv
response_tracker.sv
burst_engine.sv
ram_writer_top.sv
axi_mem_model.sv
ram_writer_assert.sv
tb_ram_writer.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ram_writer -f verilog.f -o sim_ram_writer

out=$(./obj_dir/sim_ram_writer 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
  exit 0
else
  exit 1
fi

//--- tb_ram_writer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ram_writer;

  localparam logic [31:0] SEED = 32'hc18d_9f6d;
  localparam int TOTAL_WORDS  = 960;  // Words streamed over all tests
  localparam int STALL_FACTOR = 40;
  localparam int CYCLE_LIMIT  = TOTAL_WORDS * STALL_FACTOR;

  logic aclk = 1'b0;
  logic aresetn;
  ram_writer_pkg::axi_data_t s_axis_tdata;
  logic s_axis_tvalid;
  logic s_axis_tready;
  ram_writer_pkg::axi_addr_t cfg_base;
  ram_writer_pkg::word_ptr_t sts_data;
  ram_writer_pkg::axi_id_t   awid;
  ram_writer_pkg::axi_addr_t awaddr;
  logic [3:0] awlen;
  logic [2:0] awsize;
  logic [1:0] awburst;
  logic [3:0] awcache;
  logic awvalid;
  logic awready;
  ram_writer_pkg::axi_id_t   wid;
  ram_writer_pkg::axi_data_t wdata;
  logic [7:0] wstrb;
  logic wlast;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic bready;
  logic [31:0] rnd;
  logic stall_w;
  logic hold_b;
  logic [31:0] gap_state;
  string test_name;
  int cycles = 0;

  always #50 aclk = ~aclk;

  ram_writer_top UUT (
    .aclk(aclk), .aresetn(aresetn),
    .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready), .cfg_base(cfg_base), .sts_data(sts_data),
    .m_axi_awid(awid), .m_axi_awaddr(awaddr), .m_axi_awlen(awlen),
    .m_axi_awsize(awsize), .m_axi_awburst(awburst), .m_axi_awcache(awcache),
    .m_axi_awvalid(awvalid), .m_axi_awready(awready), .m_axi_wid(wid),
    .m_axi_wdata(wdata), .m_axi_wstrb(wstrb), .m_axi_wlast(wlast),
    .m_axi_wvalid(wvalid), .m_axi_wready(wready), .m_axi_bvalid(bvalid),
    .m_axi_bready(bready)
  );

  axi_mem_model u_mem (
    .aclk(aclk), .aresetn(aresetn), .awid(awid), .awaddr(awaddr), .awlen(awlen),
    .awsize(awsize), .awburst(awburst), .awcache(awcache), .awvalid(awvalid),
    .awready(awready), .wid(wid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
    .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready), .rnd(rnd),
    .stall_w(stall_w), .hold_b(hold_b)
  );

  bind ram_writer_top ram_writer_assert u_assert (
    .aclk(aclk), .aresetn(aresetn), .awvalid(m_axi_awvalid), .awready(m_axi_awready),
    .awaddr(m_axi_awaddr), .awid(m_axi_awid), .wvalid(m_axi_wvalid),
    .wready(m_axi_wready), .wdata(m_axi_wdata), .wlast(m_axi_wlast),
    .tready(s_axis_tready), .bvalid(m_axi_bvalid)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Word idx of the stream is built from the (idx+1)-th value of the sequence
  function automatic ram_writer_pkg::axi_data_t ref_word(input int idx);
    logic [31:0] s;
    s = SEED;
    for (int k = 0; k <= idx; k++)
    begin
      s = xorshift(s);
    end
    return {s, s ^ 32'h9e37_79b9};
  endfunction

  function automatic ram_writer_pkg::axi_data_t fill_pattern(input int i);
    return {16'hf11e, 16'(i), ~16'(i), 16'(i) ^ 16'h5a5a};
  endfunction

  always @(posedge aclk)
  begin
    rnd <= xorshift(rnd);  // Ready and response timing for the model
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles in %s, the DUT stopped making progress",
               cycles, test_name);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input ram_writer_pkg::axi_data_t exp,
                            input ram_writer_pkg::axi_data_t act);
    if (exp !== act)
    begin
      fail_now($sformatf("ERROR [%s] %s expected %h actual %h", test_name, name, exp, act));
    end
  endtask

  task automatic check_ptr(input string name, input ram_writer_pkg::word_ptr_t exp,
                           input ram_writer_pkg::word_ptr_t act);
    if (exp !== act)
    begin
      fail_now($sformatf("ERROR [%s] %s expected %0d actual %0d", test_name, name, exp, act));
    end
  endtask

  task automatic check_id(input string name, input ram_writer_pkg::axi_id_t exp,
                          input ram_writer_pkg::axi_id_t act);
    if (exp !== act)
    begin
      fail_now($sformatf("ERROR [%s] %s expected %0d actual %0d", test_name, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      fail_now($sformatf("ERROR [%s] %s expected %b actual %b", test_name, name, exp, act));
    end
  endtask

  task automatic do_reset(input ram_writer_pkg::axi_addr_t base);
    @(posedge aclk);
    #1;
    aresetn = 1'b0;
    cfg_base = base;
    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    @(negedge aclk);
    check_flag("tready in first cycle after reset", 1'b0, s_axis_tready);
    @(negedge aclk);
    check_flag("tready after reset", 1'b1, s_axis_tready);
  endtask

  task automatic send_words(input int first, input int n, input bit gaps);
    logic [31:0] dstate;
    int sent;
    logic fire;
    dstate = SEED;
    for (int k = 0; k <= first; k++)
    begin
      dstate = xorshift(dstate);
    end
    sent = 0;
    @(posedge aclk);
    #1;
    while (sent < n)
    begin
      if (!s_axis_tvalid)
      begin
        gap_state = xorshift(gap_state);
        s_axis_tvalid = !gaps || (gap_state[3:0] > 4'd3);
      end
      s_axis_tdata = {dstate, dstate ^ 32'h9e37_79b9};
      @(negedge aclk);
      fire = s_axis_tvalid && s_axis_tready;
      @(posedge aclk);
      #1;
      if (fire)
      begin
        sent++;
        dstate = xorshift(dstate);
        s_axis_tvalid = 1'b0;
      end
    end
  endtask

  // Status follows the last response by one cycle
  task automatic wait_responses(input int bursts);
    while (u_mem.b_count < bursts)
    begin
      @(negedge aclk);
    end
    @(negedge aclk);
  endtask

  task automatic check_mem(input ram_writer_pkg::axi_addr_t base, input int n);
    for (int i = 0; i < n; i++)
    begin
      check_data($sformatf("memory word %0d", i), ref_word(i),
                 u_mem.mem[14'(base[16:3] + 14'(i))]);
    end
  endtask

  // IDs start at zero after reset and wrap at 64
  task automatic check_bursts(input int n);
    check_ptr("burst count", ram_writer_pkg::word_ptr_t'(n),
              ram_writer_pkg::word_ptr_t'(u_mem.aw_count));
    check_ptr("data burst count", ram_writer_pkg::word_ptr_t'(n),
              ram_writer_pkg::word_ptr_t'(u_mem.wid_log.size()));
    for (int k = 0; k < n; k++)
    begin
      check_id($sformatf("burst %0d awid", k), ram_writer_pkg::axi_id_t'(k),
               u_mem.id_log[k]);
      check_id($sformatf("burst %0d wid", k), ram_writer_pkg::axi_id_t'(k),
               u_mem.wid_log[k]);
    end
    check_ptr("burst format errors", '0, ram_writer_pkg::word_ptr_t'(u_mem.fmt_err));
  endtask

  initial
  begin
    aresetn = 1'b0;
    s_axis_tdata = '0;
    s_axis_tvalid = 1'b0;
    cfg_base = '0;
    stall_w = 1'b0;
    hold_b = 1'b0;
    rnd = SEED ^ 32'h3c6e_f372;
    gap_state = SEED ^ 32'h0bad_5eed;

    // Plain run with random gaps and stalls
    test_name = "plain run";
    do_reset(32'h0001_0000);
    send_words(0, 160, 1'b1);
    wait_responses(10);
    check_ptr("status after 160 words", 20'd160, sts_data);
    check_mem(32'h0001_0000, 160);
    check_bursts(10);

    // A tail shorter than a burst stays in the FIFO
    test_name = "short tail";
    do_reset(32'h0001_8000);
    send_words(0, 40, 1'b1);
    wait_responses(2);
    repeat (100) @(negedge aclk);
    check_ptr("status after 40 words", 20'd32, sts_data);
    check_mem(32'h0001_8000, 32);
    for (int i = 32; i < 40; i++)
    begin
      check_data($sformatf("unwritten word %0d", i), fill_pattern(14'h3000 + i),
                 u_mem.mem[14'h3000 + i]);
    end
    check_bursts(2);

    // Data channel stalled until the FIFO fills up
    test_name = "full FIFO";
    do_reset(32'h0001_4000);
    stall_w = 1'b1;
    send_words(0, 512, 1'b0);
    repeat (20) @(negedge aclk);
    check_flag("tready with full FIFO", 1'b0, s_axis_tready);
    #1;
    stall_w = 1'b0;
    send_words(512, 88, 1'b0);
    wait_responses(37);
    check_ptr("status after 600 words", 20'd592, sts_data);
    check_mem(32'h0001_4000, 592);
    check_bursts(37);

    // Responses withheld until the credit runs out
    test_name = "responses withheld";
    do_reset(32'h0001_c000);
    hold_b = 1'b1;
    send_words(0, 160, 1'b1);
    while (u_mem.aw_count < ram_writer_pkg::MAX_OUTSTANDING)
    begin
      @(negedge aclk);
    end
    repeat (50) @(negedge aclk);
    check_ptr("bursts issued without response", 20'd4,
              ram_writer_pkg::word_ptr_t'(u_mem.aw_count));
    check_ptr("status with responses held", 20'd0, sts_data);
    #1;
    hold_b = 1'b0;
    wait_responses(10);
    check_ptr("status after responses released", 20'd160, sts_data);
    check_mem(32'h0001_c000, 160);
    check_bursts(10);
    if (u_mem.max_outst > ram_writer_pkg::MAX_OUTSTANDING)
    begin
      fail_now($sformatf("More than %0d bursts were outstanding at once",
                         ram_writer_pkg::MAX_OUTSTANDING));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- ram_writer_assert.sv
`timescale 1ns/100ps
`default_nettype none

module ram_writer_assert (
  input wire                            aclk,
  input wire                            aresetn,
  input wire                            awvalid,
  input wire                            awready,
  input wire ram_writer_pkg::axi_addr_t awaddr,
  input wire ram_writer_pkg::axi_id_t   awid,
  input wire                            wvalid,
  input wire                            wready,
  input wire ram_writer_pkg::axi_data_t wdata,
  input wire                            wlast,
  input wire                            tready,
  input wire                            bvalid
);

  int   outst = 0;
  logic in_reset = 1'b0;  // Set after the first reset edge

  always @(posedge aclk)
  begin
    in_reset <= !aresetn;
    if (!aresetn)
    begin
      outst <= 0;
    end
    else
    begin
      outst <= outst + int'(awvalid && awready) - int'(bvalid);
    end
  end

  aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
    else $error("awvalid or address dropped while stalled");

  w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else $error("wvalid or write data dropped while stalled");

  outst_limit: assert property (@(posedge aclk) disable iff (!aresetn)
    outst <= ram_writer_pkg::MAX_OUTSTANDING)
    else $error("too many bursts outstanding");

  reset_quiet: assert property (@(posedge aclk)
    !aresetn && in_reset |-> !awvalid && !wvalid && !tready)
    else $error("valid or tready high during reset");

endmodule

`default_nettype wire

//--- axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model (
  input  wire                            aclk,
  input  wire                            aresetn,
  input  wire ram_writer_pkg::axi_id_t   awid,
  input  wire ram_writer_pkg::axi_addr_t awaddr,
  input  wire [3:0]                      awlen,
  input  wire [2:0]                      awsize,
  input  wire [1:0]                      awburst,
  input  wire [3:0]                      awcache,
  input  wire                            awvalid,
  output logic                           awready,
  input  wire ram_writer_pkg::axi_id_t   wid,
  input  wire ram_writer_pkg::axi_data_t wdata,
  input  wire [7:0]                      wstrb,
  input  wire                            wlast,
  input  wire                            wvalid,
  output logic                           wready,
  output logic                           bvalid,
  input  wire                            bready,
  input  wire [31:0]                     rnd,      // Random bits from the testbench
  input  wire                            stall_w,  // Hold wready low
  input  wire                            hold_b    // Withhold responses
);

  ram_writer_pkg::axi_data_t mem [0:16383];  // Indexed by byte address bits 16:3

  ram_writer_pkg::axi_addr_t aw_q[$];
  ram_writer_pkg::axi_data_t w_q[$];
  ram_writer_pkg::axi_id_t   id_log[$];
  ram_writer_pkg::axi_id_t   wid_log[$];  // ID seen on the first beat of each burst
  int                        b_due[$];  // Cycle at which each response may go out
  int                        beat;
  int                        cyc;
  int                        aw_count;
  int                        b_count;
  int                        max_outst;
  int                        fmt_err;

  initial
  begin
    for (int i = 0; i < 16384; i++)
    begin
      mem[i] = {16'hf11e, 16'(i), ~16'(i), 16'(i) ^ 16'h5a5a};
    end
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
  end

  // Channel values are stable at the falling edge, so handshakes are taken here
  always @(negedge aclk)
  begin
    ram_writer_pkg::axi_addr_t addr;
    if (!aresetn)
    begin
      aw_q.delete();
      w_q.delete();
      id_log.delete();
      wid_log.delete();
      b_due.delete();
      beat = 0;
      cyc = 0;
      aw_count = 0;
      b_count = 0;
    end
    else
    begin
      if (awvalid && awready)
      begin
        aw_q.push_back(awaddr);
        id_log.push_back(awid);
        aw_count++;
        // Cacheable with read allocate
        if (awlen != 4'd15 || awsize != 3'd3 || awburst != 2'b01 || awcache != 4'b0110)
        begin
          fmt_err++;
        end
        if (aw_count - b_count > max_outst)
        begin
          max_outst = aw_count - b_count;
        end
      end
      if (wvalid && wready)
      begin
        w_q.push_back(wdata);
        if (wstrb != 8'hff || wlast != (beat == 15))
        begin
          fmt_err++;
        end
        if (beat == 0)
        begin
          wid_log.push_back(wid);
        end
        else if (wid != wid_log[wid_log.size()-1])  // One ID for all beats of a burst
        begin
          fmt_err++;
        end
        beat = (beat + 1) % 16;
      end
      if (bvalid && bready)
      begin
        b_count++;
      end
      if (aw_q.size() > 0 && w_q.size() >= 16)  // One whole burst ready to commit
      begin
        addr = aw_q.pop_front();
        for (int k = 0; k < 16; k++)
        begin
          mem[14'(addr[16:3] + 14'(k))] = w_q.pop_front();
        end
        b_due.push_back(cyc + 1 + int'(rnd[7:5]));
      end
    end
  end

  always @(posedge aclk)
  begin
    #1;
    if (!aresetn)
    begin
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
    end
    else
    begin
      cyc++;
      awready = rnd[0] | rnd[1];
      wready  = !stall_w && (rnd[2] | rnd[3] | rnd[4]);
      bvalid  = 1'b0;
      if (!hold_b && b_due.size() > 0 && cyc >= b_due[0])
      begin
        void'(b_due.pop_front());
        bvalid = 1'b1;  // One-cycle pulse, bready is always high
      end
    end
  end

endmodule

`default_nettype wire

//--- ram_writer_top.sv
`timescale 1ns/100ps
`default_nettype none

module ram_writer_top (
  input  wire                           aclk,
  input  wire                           aresetn,
  input  wire ram_writer_pkg::axi_data_t   s_axis_tdata,
  input  wire                           s_axis_tvalid,
  output logic                          s_axis_tready,
  input  wire ram_writer_pkg::axi_addr_t   cfg_base,
  output ram_writer_pkg::word_ptr_t     sts_data,
  output ram_writer_pkg::axi_id_t       m_axi_awid,
  output ram_writer_pkg::axi_addr_t     m_axi_awaddr,
  output logic [3:0]                    m_axi_awlen,
  output logic [2:0]                    m_axi_awsize,
  output logic [1:0]                    m_axi_awburst,
  output logic [3:0]                    m_axi_awcache,
  output logic                          m_axi_awvalid,
  input  wire                           m_axi_awready,
  output ram_writer_pkg::axi_id_t       m_axi_wid,
  output ram_writer_pkg::axi_data_t     m_axi_wdata,
  output logic [ram_writer_pkg::AXI_DATA_WIDTH/8-1:0] m_axi_wstrb,
  output logic                          m_axi_wlast,
  output logic                          m_axi_wvalid,
  input  wire                           m_axi_wready,
  input  wire                           m_axi_bvalid,
  output logic                          m_axi_bready
);

  ram_writer_pkg::axi_data_t   fifo_dout;
  ram_writer_pkg::fifo_count_t fifo_count;
  logic                        fifo_full;
  logic                        fifo_rd;
  logic                        credit_ok;
  logic                        aw_fire;

  assign aw_fire       = m_axi_awvalid & m_axi_awready;
  assign s_axis_tready = ~fifo_full;

  stream_fifo u_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (s_axis_tvalid),  // Gated by full inside the FIFO
    .din     (s_axis_tdata),
    .full    (fifo_full),
    .rd_en   (fifo_rd),
    .dout    (fifo_dout),
    .count   (fifo_count)
  );

  response_tracker u_tracker (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .aw_fire   (aw_fire),
    .bvalid    (m_axi_bvalid),
    .credit_ok (credit_ok),
    .sts_data  (sts_data)
  );

  burst_engine u_engine (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cfg_base   (cfg_base),
    .fifo_count (fifo_count),
    .fifo_dout  (fifo_dout),
    .credit_ok  (credit_ok),
    .fifo_rd    (fifo_rd),
    .awid       (m_axi_awid),
    .awaddr     (m_axi_awaddr),
    .awlen      (m_axi_awlen),
    .awsize     (m_axi_awsize),
    .awburst    (m_axi_awburst),
    .awcache    (m_axi_awcache),
    .awvalid    (m_axi_awvalid),
    .awready    (m_axi_awready),
    .wid        (m_axi_wid),
    .wdata      (m_axi_wdata),
    .wstrb      (m_axi_wstrb),
    .wlast      (m_axi_wlast),
    .wvalid     (m_axi_wvalid),
    .wready     (m_axi_wready),
    .bready     (m_axi_bready)
  );

endmodule

`default_nettype wire

//--- burst_engine.sv
`timescale 1ns/100ps
`default_nettype none

module burst_engine (
  input  wire                           aclk,
  input  wire                           aresetn,
  input  wire ram_writer_pkg::axi_addr_t   cfg_base,
  input  wire ram_writer_pkg::fifo_count_t fifo_count,
  input  wire ram_writer_pkg::axi_data_t   fifo_dout,
  input  wire                           credit_ok,
  output logic                          fifo_rd,
  output ram_writer_pkg::axi_id_t       awid,
  output ram_writer_pkg::axi_addr_t     awaddr,
  output logic [3:0]                    awlen,
  output logic [2:0]                    awsize,
  output logic [1:0]                    awburst,
  output logic [3:0]                    awcache,
  output logic                          awvalid,
  input  wire                           awready,
  output ram_writer_pkg::axi_id_t       wid,
  output ram_writer_pkg::axi_data_t     wdata,
  output logic [ram_writer_pkg::AXI_DATA_WIDTH/8-1:0] wstrb,
  output logic                          wlast,
  output logic                          wvalid,
  input  wire                           wready,
  output logic                          bready
);

  typedef enum logic {
    idle,
    busy
  } engine_state_t;

  engine_state_t             state;
  ram_writer_pkg::word_ptr_t ptr;     // Next word to send on the data channel
  ram_writer_pkg::axi_id_t   id;      // ID of the burst on the data channel
  ram_writer_pkg::word_ptr_t aw_ptr;  // First word of the burst on the address channel
  ram_writer_pkg::axi_id_t   aw_id;

  logic aw_fire;
  logic w_fire;
  logic last_beat;
  logic start_burst;
  logic next_burst;

  assign aw_fire   = awvalid & awready;
  assign w_fire    = wvalid & wready;
  assign wlast     = &ptr[3:0];
  assign last_beat = w_fire & wlast;

  // A pending address is not yet in the tracker, so wait for it before a new one
  assign start_burst = (state == idle) && !awvalid && credit_ok &&
    (fifo_count >= ram_writer_pkg::fifo_count_t'(ram_writer_pkg::BURST_LEN));
  assign next_burst = last_beat && !awvalid && credit_ok &&
    (fifo_count > ram_writer_pkg::fifo_count_t'(ram_writer_pkg::BURST_LEN));

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state   <= idle;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      ptr     <= '0;
      id      <= '0;
    end
    else
    begin
      if (aw_fire)
      begin
        awvalid <= 1'b0;
      end
      if (start_burst || next_burst)
      begin
        awvalid <= 1'b1;  // Address and data start independently
      end
      if (start_burst)
      begin
        state  <= busy;
        wvalid <= 1'b1;
      end
      else if (last_beat && !next_burst)
      begin
        state  <= idle;
        wvalid <= 1'b0;
      end
      if (w_fire)
      begin
        ptr <= ptr + ram_writer_pkg::word_ptr_t'(1);
      end
      if (last_beat)
      begin
        id <= id + ram_writer_pkg::axi_id_t'(1);
      end
    end
  end

  // Address fields are latched so they hold while data beats move on
  always_ff @(posedge aclk)
  begin
    if (start_burst)
    begin
      aw_ptr <= ptr;
      aw_id  <= id;
    end
    else if (next_burst)
    begin
      aw_ptr <= ptr + ram_writer_pkg::word_ptr_t'(1);  // Word after this last beat
      aw_id  <= id + ram_writer_pkg::axi_id_t'(1);
    end
  end

  assign fifo_rd = w_fire;

  assign awid    = aw_id;
  assign awaddr  = cfg_base + (ram_writer_pkg::axi_addr_t'(aw_ptr)
                   << ram_writer_pkg::BEAT_BYTES_LOG2);
  assign awlen   = 4'(ram_writer_pkg::BURST_LEN - 1);
  assign awsize  = 3'(ram_writer_pkg::BEAT_BYTES_LOG2);
  assign awburst = 2'b01;   // INCR
  assign awcache = 4'b0110; // Write-through, read allocate
  assign wid     = id;
  assign wdata   = fifo_dout;
  assign wstrb   = '1;      // Full-width beats only
  assign bready  = 1'b1;

endmodule

`default_nettype wire

//--- response_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module response_tracker (
  input  wire                       aclk,
  input  wire                       aresetn,
  input  wire                       aw_fire,   // Address accepted by the slave
  input  wire                       bvalid,    // bready is tied high
  output logic                      credit_ok,
  output ram_writer_pkg::word_ptr_t sts_data
);

  // Bursts whose address went out and whose response has not arrived
  ram_writer_pkg::outst_count_t outstanding;

  assign credit_ok =
    (outstanding < ram_writer_pkg::outst_count_t'(ram_writer_pkg::MAX_OUTSTANDING));

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      outstanding <= '0;
    end
    else
    begin
      case ({aw_fire, bvalid})
        2'b10:
        begin
          outstanding <= outstanding + ram_writer_pkg::outst_count_t'(1);
        end
        2'b01:
        begin
          outstanding <= outstanding - ram_writer_pkg::outst_count_t'(1);
        end
        default:
        begin
          outstanding <= outstanding;  // Both or neither, count unchanged
        end
      endcase
    end
  end

  // Every response confirms one full burst of words
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      sts_data <= '0;
    end
    else if (bvalid)
    begin
      sts_data <= sts_data + ram_writer_pkg::word_ptr_t'(ram_writer_pkg::BURST_LEN);
    end
  end

endmodule

`default_nettype wire

//--- stream_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module stream_fifo (
  input  wire                         aclk,
  input  wire                         aresetn,
  input  wire                         wr_en,
  input  wire ram_writer_pkg::axi_data_t din,
  output logic                        full,
  input  wire                         rd_en,
  output ram_writer_pkg::axi_data_t   dout,
  output ram_writer_pkg::fifo_count_t count
);

  ram_writer_pkg::axi_data_t mem [0:ram_writer_pkg::FIFO_DEPTH-1];

  logic [ram_writer_pkg::COUNT_WIDTH-2:0] wr_ptr;  // Wraps at FIFO_DEPTH
  logic [ram_writer_pkg::COUNT_WIDTH-2:0] rd_ptr;
  ram_writer_pkg::fifo_count_t            count_next;
  logic                                   wr_ok;
  logic                                   rd_ok;

  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & (count != '0);  // Never read past the last word

  // Head of queue shows on dout without a read strobe
  assign dout = mem[rd_ptr];

  always_comb
  begin
    count_next = count;
    if (wr_ok && !rd_ok)
    begin
      count_next = count + ram_writer_pkg::fifo_count_t'(1);
    end
    else if (rd_ok && !wr_ok)
    begin
      count_next = count - ram_writer_pkg::fifo_count_t'(1);
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b1;  // Holds the stream off until reset is released
    end
    else
    begin
      if (wr_ok)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      full  <= (count_next == ram_writer_pkg::fifo_count_t'(ram_writer_pkg::FIFO_DEPTH));
    end
  end

  always_ff @(posedge aclk)
  begin
    if (wr_ok)
    begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

`default_nettype wire

//--- ram_writer_pkg.sv
`default_nettype none

package ram_writer_pkg;

  localparam int AXI_ADDR_WIDTH  = 32;  // Byte address
  localparam int AXI_DATA_WIDTH  = 64;  // Stream and AXI data
  localparam int AXI_ID_WIDTH    = 6;
  localparam int PTR_WIDTH       = 20;  // Word pointer and status count
  localparam int FIFO_DEPTH      = 512;
  localparam int COUNT_WIDTH     = 10;  // Holds 0 to FIFO_DEPTH
  localparam int BURST_LEN       = 16;  // Beats per burst
  localparam int BEAT_BYTES_LOG2 = 3;   // 8 bytes per beat
  localparam int MAX_OUTSTANDING = 4;   // Bursts in flight without a response
  localparam int OUTST_WIDTH     = 3;

  typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
  typedef logic [PTR_WIDTH-1:0]      word_ptr_t;
  typedef logic [COUNT_WIDTH-1:0]    fifo_count_t;
  typedef logic [OUTST_WIDTH-1:0]    outst_count_t;

endpackage

`default_nettype wire
